// File: aesColumn.f
+incdir+.
aesTypesPkg.sv
aesApbPkg.sv
aesColumnIfs.sv
aesRoundCtrl.sv
tTableLookup.sv
keyXorChain.sv
aesColumnTop.sv
aesColumn_assert.sv
aesColumn_tb.sv

// File: runSim.sh
#!/bin/sh
# build and run the aesColumn testbench with Verilator, pass only if the log holds the pass line
rm -f sim.log
verilator --binary --assert --top-module aesColumn_tb -f aesColumn.f -o aesColumnSim \
    && ./obj_dir/aesColumnSim 2>&1 | tee sim.log \
    && grep -q "^Test OK$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: aesColumn_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "aesColumn_macros.svh"

module aesColumn_tb;

    localparam logic [`APB_ADDR_W-1:0] OFS_COLUMN = 5'h00;
    localparam logic [`APB_ADDR_W-1:0] OFS_KEY    = 5'h04;
    localparam logic [`APB_ADDR_W-1:0] OFS_CTRL   = 5'h08;
    localparam logic [`APB_ADDR_W-1:0] OFS_STATUS = 5'h0C;
    localparam logic [`APB_ADDR_W-1:0] OFS_RESULT = 5'h10;
    localparam int TIMEOUT_CYCLES = 2000;  // ~40 jobs of under 30 cycles plus polling, with margin
    localparam int FIRST_JOB_STALLS = 6;   // issue cycle plus 6 pipeline cycles, less the setup cycle

    logic                   CLK;
    logic                   reset;
    logic                   pSel;
    logic                   pEnable;
    logic                   pWrite;
    logic [`APB_ADDR_W-1:0] pAddr;
    logic [31:0]            pWdata;
    logic [31:0]            pRdata;
    logic                   pReady;
    logic                   pSlvErr;
    logic [7:0]             sTab [256];  // reference S-box
    int                     errors;
    int                     checks;
    int                     cycleCount;

    aesColumnTop uut (
        .CLK     (CLK),
        .reset   (reset),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWdata  (pWdata),
        .pRdata  (pRdata),
        .pReady  (pReady),
        .pSlvErr (pSlvErr)
    );

    initial
    begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // carry-less product reduced by the AES polynomial
    function automatic logic [7:0] gfProduct(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
        end
        return acc;
    endfunction

    // brute-force inverse, then the affine map bit by bit
    task automatic buildSbox();
        logic [7:0] inv;
        logic [7:0] s;
        for (int x = 0; x < 256; x++)
        begin
            inv = 8'h00;
            for (int y = 1; y < 256; y++)
                if (gfProduct(x[7:0], y[7:0]) == 8'h01)
                    inv = y[7:0];
            for (int i = 0; i < 8; i++)
                s[i] = inv[i] ^ inv[(i+4)%8] ^ inv[(i+5)%8] ^ inv[(i+6)%8] ^ inv[(i+7)%8];
            sTab[x] = s ^ 8'h63;
        end
    endtask

    function automatic logic [7:0] invSbox(input logic [7:0] b);
        logic [7:0] x;
        x = 8'h00;
        for (int i = 0; i < 256; i++)
            if (sTab[i] == b)
                x = i[7:0];
        return x;
    endfunction

    // key XOR four lane entries, lane r from byte r counted from the top
    function automatic logic [31:0] expectedWord(input logic [31:0] col, input logic [31:0] key,
                                                 input logic [3:0] mask);
        logic [31:0] acc;
        logic [31:0] t0;
        logic [7:0]  s;
        logic [7:0]  s2;
        acc = key;
        for (int r = 0; r < 4; r++)
        begin
            s = sTab[col[31-8*r -: 8]];
            s2 = {s[6:0], 1'b0} ^ (s[7] ? 8'h1b : 8'h00);
            t0 = {s2, s, s, s2 ^ s};
            if (mask[r])
                acc = acc ^ ({24'h000000, s} << (24 - 8*r));  // plain byte in row r
            else
                case (r)
                    0: acc = acc ^ t0;
                    1: acc = acc ^ {t0[7:0], t0[31:8]};
                    2: acc = acc ^ {t0[15:0], t0[31:16]};
                    default: acc = acc ^ {t0[23:0], t0[31:24]};
                endcase
        end
        return acc;
    endfunction

    // one APB transfer, called 2 ns after a rising edge
    task automatic apbTransfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic err, output int stalls);
        pSel = 1'b1;
        pEnable = 1'b0;
        pWrite = wr;
        pAddr = addr;
        pWdata = wdata;
        @(posedge CLK);
        #2;
        pEnable = 1'b1;
        stalls = 0;
        @(negedge CLK);
        while (!pReady)
        begin
            stalls++;
            @(negedge CLK);
        end
        rdata = pRdata;
        err = pSlvErr;
        @(posedge CLK);  // completing edge
        #2;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
    endtask

    task automatic writeReg(input logic [`APB_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic        err;
        int          stalls;
        apbTransfer(1'b1, addr, data, rd, err, stalls);
        checks++;
        if (err)
        begin
            errors++;
            $display("Unexpected pSlvErr on write to offset %h", addr);
        end
    endtask

    task automatic checkRead(input string name, input logic [`APB_ADDR_W-1:0] addr,
                             input logic [31:0] expected);
        logic [31:0] rd;
        logic        err;
        int          stalls;
        apbTransfer(1'b0, addr, 32'h0, rd, err, stalls);
        checks++;
        if (err)
        begin
            errors++;
            $display("Unexpected pSlvErr on read of offset %h in %s", addr, name);
        end
        if (rd !== expected)
        begin
            errors++;
            $display("Mismatch %s: expected %h actual %h", name, expected, rd);
        end
    endtask

    task automatic waitDone(input string name);
        logic [31:0] rd;
        logic        err;
        int          stalls;
        int          polls;
        rd = 32'h0;
        polls = 0;
        while (!rd[1] && polls < 60)
        begin
            apbTransfer(1'b0, OFS_STATUS, 32'h0, rd, err, stalls);
            polls++;
        end
        checks++;
        if (!rd[1])
        begin
            errors++;
            $display("Done never set in %s", name);
        end
    endtask

    task automatic runJob(input string name, input logic [31:0] col, input logic [31:0] key,
                          input logic [3:0] mask);
        writeReg(OFS_COLUMN, col);
        writeReg(OFS_KEY, key);
        writeReg(OFS_CTRL, {23'h0, 1'b1, 4'h0, mask});  // start bit 8
        waitDone(name);
        checkRead(name, OFS_RESULT, expectedWord(col, key, mask));
        checkRead(name, OFS_STATUS, 32'h2);  // done set, busy clear
    endtask

    task automatic testReset();
        checkRead("reset status", OFS_STATUS, 32'h0);
        checkRead("reset result", OFS_RESULT, 32'h0);
    endtask

    task automatic testNormalRound();
        logic [31:0] col;
        // column chosen so that SubBytes gives db 13 53 45
        col = {invSbox(8'hdb), invSbox(8'h13), invSbox(8'h53), invSbox(8'h45)};
        runJob("fips column", col, 32'h0, 4'h0);
        checkRead("fips column literal", OFS_RESULT, 32'h8e4da1bc);
        for (int i = 0; i < 20; i++)
            runJob("normal round", $urandom(), $urandom(), 4'h0);
    endtask

    task automatic testMasks();
        for (int m = 15; m > 0; m--)
            runJob("lane mask", $urandom(), $urandom(), m[3:0]);
    endtask

    task automatic testBackPressure();
        logic [31:0] col;
        logic [31:0] key;
        logic [31:0] rd;
        logic        err;
        int          stalls;
        col = $urandom();
        key = $urandom();
        writeReg(OFS_COLUMN, col);
        writeReg(OFS_KEY, key);
        writeReg(OFS_CTRL, {23'h0, 1'b1, 8'h00});
        apbTransfer(1'b1, OFS_CTRL, {23'h0, 1'b1, 8'h0F}, rd, err, stalls);
        checks++;
        if (stalls < FIRST_JOB_STALLS || err)
        begin
            errors++;
            $display("Second start was not held off until done (stalls %0d)", stalls);
        end
        // first result must already be captured when the second start is taken
        checkRead("back-pressure first", OFS_RESULT, expectedWord(col, key, 4'h0));
        waitDone("back-pressure second");
        checkRead("back-pressure second", OFS_RESULT, expectedWord(col, key, 4'hF));
    endtask

    task automatic testSlvErr();
        logic [31:0] rd;
        logic        err;
        int          stalls;
        writeReg(OFS_COLUMN, 32'h1234_5678);
        writeReg(OFS_KEY, 32'hcafe_f00d);
        writeReg(OFS_CTRL, 32'h0000_0005);
        for (int a = 'h14; a < 'h20; a += 4)
        begin
            apbTransfer(1'b1, a[`APB_ADDR_W-1:0], 32'hffff_ffff, rd, err, stalls);
            checks++;
            if (!err)
            begin
                errors++;
                $display("No pSlvErr on write to unmapped offset %h", a);
            end
            apbTransfer(1'b0, a[`APB_ADDR_W-1:0], 32'h0, rd, err, stalls);
            checks++;
            if (!err)
            begin
                errors++;
                $display("No pSlvErr on read of unmapped offset %h", a);
            end
        end
        checkRead("slverr column", OFS_COLUMN, 32'h1234_5678);
        checkRead("slverr key", OFS_KEY, 32'hcafe_f00d);
        checkRead("slverr ctrl", OFS_CTRL, 32'h0000_0005);
    endtask

    initial
    begin
        void'($urandom(32'ha1e4_3f3b));
        errors = 0;
        checks = 0;
        cycleCount = 0;
        reset = 1'b1;
        pSel = 1'b0;
        pEnable = 1'b0;
        pWrite = 1'b0;
        pAddr = '0;
        pWdata = 32'h0;
        buildSbox();
        repeat (5) @(posedge CLK);
        #2;
        reset = 1'b0;
        testReset();
        testNormalRound();
        testMasks();
        testBackPressure();
        testSlvErr();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, uut.uAssert.assertFails);
        if (errors == 0 && uut.uAssert.assertFails == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: aesColumn_assert.sv
`timescale 1ns/1ps
`default_nettype none

module aesColumn_assert
(
    input wire CLK,
    input wire reset,
    input wire pSel,
    input wire pEnable,
    input wire pReady,
    input wire issue,
    input wire resultValid
);

    int assertFails = 0;  // failed assertions so far

    // access phase only right after a setup phase
    property accessAfterSetup;
        @(posedge CLK) disable iff (reset)
            $rose(pEnable) |-> $past(pSel && !pEnable) && pSel;
    endproperty

    property issueToResult;
        @(posedge CLK) disable iff (reset)
            issue |-> ##6 resultValid;
    endproperty

    property resultAfterIssue;
        @(posedge CLK) disable iff (reset)
            resultValid |-> $past(issue, 6);
    endproperty

    // a held start is let through once the job in flight is done
    property stallReleased;
        @(posedge CLK) disable iff (reset)
            !pReady |-> ##[1:7] pReady;
    endproperty

    aSetup: assert property (accessAfterSetup)
        else
        begin
            assertFails++;
            $error("pEnable rose without a setup phase");
        end
    aIssue: assert property (issueToResult)
        else
        begin
            assertFails++;
            $error("no result 6 cycles after issue");
        end
    aValid: assert property (resultAfterIssue)
        else
        begin
            assertFails++;
            $error("resultValid without an issue");
        end
    aStall: assert property (stallReleased)
        else
        begin
            assertFails++;
            $error("pReady held low longer than one job");
        end

endmodule

bind aesColumnTop aesColumn_assert uAssert (
    .CLK         (CLK),
    .reset       (reset),
    .pSel        (pSel),
    .pEnable     (pEnable),
    .pReady      (pReady),
    .issue       (issueBus.issue),
    .resultValid (resultValid)
);

`default_nettype wire

// File: aesColumnTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "aesColumn_macros.svh"

module aesColumnTop
    import aesTypesPkg::*;
(
    input  wire           CLK,
    input  wire           reset,
    input  wire           pSel,
    input  wire           pEnable,
    input  wire           pWrite,
    input  wire [`APB_ADDR_W-1:0] pAddr,
    input  wire aesWord_t pWdata,
    output aesWord_t      pRdata,
    output logic          pReady,
    output logic          pSlvErr
);

    aesWord_t resultWord;
    logic     resultValid;

    issueIf issueBus ();
    laneIf  laneBus ();

    aesRoundCtrl uCtrl (
        .CLK         (CLK),
        .reset       (reset),
        .pSel        (pSel),
        .pEnable     (pEnable),
        .pWrite      (pWrite),
        .pAddr       (pAddr),
        .pWdata      (pWdata),
        .pRdata      (pRdata),
        .pReady      (pReady),
        .pSlvErr     (pSlvErr),
        .issueBus    (issueBus.ctrl),
        .resultWord  (resultWord),
        .resultValid (resultValid)
    );

    // two cycles issue to lanes
    tTableLookup uLookup (
        .CLK      (CLK),
        .reset    (reset),
        .issueBus (issueBus.lookup),
        .laneBus  (laneBus.src)
    );

    // four more cycles lanes to result
    keyXorChain uXor (
        .CLK         (CLK),
        .reset       (reset),
        .laneBus     (laneBus.dst),
        .resultWord  (resultWord),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// File: keyXorChain.sv
`timescale 1ns/1ps
`default_nettype none

`include "aesColumn_macros.svh"

module keyXorChain
    import aesTypesPkg::*;
(
    input  wire      CLK,
    input  wire      reset,
    laneIf.dst       laneBus,
    output aesWord_t resultWord,
    output logic     resultValid
);

    aesWord_t                sumPipe  [`XOR_STAGES];
    laneWords_t              lanePipe [`XOR_STAGES-1];
    logic [`XOR_STAGES-1:0]  validPipe;

    // lanePipe[j] holds the lanes from j+1 cycles back, so stage k picks
    // lane k after k delay registers and meets the running sum of the
    // same issue
    always_ff @(posedge CLK)
    begin
        sumPipe[0] <= laneBus.laneWord[0] ^ laneBus.laneKey;  // lane 0 meets the key
        lanePipe[0] <= laneBus.laneWord;
        for (int k = 1; k < `XOR_STAGES; k++)
            sumPipe[k] <= sumPipe[k-1] ^ lanePipe[k-1][k];
        for (int j = 1; j < `XOR_STAGES - 1; j++)
            lanePipe[j] <= lanePipe[j-1];
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
            validPipe <= '0;
        else
            validPipe <= {validPipe[`XOR_STAGES-2:0], laneBus.laneValid};
    end

    assign resultWord = sumPipe[`XOR_STAGES-1];
    assign resultValid = validPipe[`XOR_STAGES-1];

endmodule

`default_nettype wire

// File: tTableLookup.sv
`timescale 1ns/1ps
`default_nettype none

`include "aesColumn_macros.svh"

module tTableLookup
    import aesTypesPkg::*;
    import aesApbPkg::*;
(
    input  wire     CLK,
    input  wire     reset,
    issueIf.lookup  issueBus,
    laneIf.src      laneBus
);

    laneWords_t              tEntry;
    laneWords_t              entryPipe [`LOOKUP_STAGES];
    aesWord_t                keyPipe   [`LOOKUP_STAGES];
    logic [`LOOKUP_STAGES-1:0] validPipe;

    // Lane r looks up byte r counted from the top of the column. T0 of s is
    // {2s, s, s, 3s}; T_r is that word rotated right by r bytes. The final
    // round entry is the S-box byte moved to row r by the same rotation.
    always_comb
    begin
        for (int r = 0; r < `AES_LANES; r++)
        begin
            aesByte_t sb;
            aesWord_t base;
            sb = sbox(issueBus.colWord[`AES_WORD_W-1-`AES_BYTE_W*r -: `AES_BYTE_W]);
            if (issueBus.lastMask[r])
                base = {sb, 24'h000000};
            else
                base = {xtime(sb), sb, sb, xtime(sb) ^ sb};
            tEntry[r] = (base >> (`AES_BYTE_W * r))
                      | (base << (`AES_WORD_W - `AES_BYTE_W * r));
        end
    end

    // table read register followed by the output register
    always_ff @(posedge CLK)
    begin
        entryPipe[0] <= tEntry;
        keyPipe[0] <= issueBus.roundKey;  // key rides along with its lanes
        for (int i = 1; i < `LOOKUP_STAGES; i++)
        begin
            entryPipe[i] <= entryPipe[i-1];
            keyPipe[i] <= keyPipe[i-1];
        end
    end

    always_ff @(posedge CLK)
    begin
        if (reset)
            validPipe <= '0;
        else
            validPipe <= {validPipe[`LOOKUP_STAGES-2:0], issueBus.issue};
    end

    assign laneBus.laneWord = entryPipe[`LOOKUP_STAGES-1];
    assign laneBus.laneKey = keyPipe[`LOOKUP_STAGES-1];
    assign laneBus.laneValid = validPipe[`LOOKUP_STAGES-1];

endmodule

`default_nettype wire

// File: aesRoundCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "aesColumn_macros.svh"

module aesRoundCtrl
    import aesTypesPkg::*;
    import aesApbPkg::*;
(
    input  wire           CLK,
    input  wire           reset,
    input  wire           pSel,
    input  wire           pEnable,
    input  wire           pWrite,
    input  wire [`APB_ADDR_W-1:0] pAddr,
    input  wire aesWord_t pWdata,
    output aesWord_t      pRdata,
    output logic          pReady,
    output logic          pSlvErr,
    issueIf.ctrl          issueBus,
    input  wire aesWord_t resultWord,
    input  wire           resultValid
);

    regAddr_e   regSel;
    ctrlReg_t   wrCtrl;
    ctrlReg_t   rdCtrl;
    statusReg_t rdStatus;
    logic       apbAccess;
    logic       addrHit;
    logic       startReq;
    logic       startFire;
    logic       wrFire;
    logic       issueReg;
    logic       busy;
    logic       done;
    aesWord_t   colReg;
    aesWord_t   keyReg;
    laneMask_t  maskReg;
    aesWord_t   resultReg;

    assign regSel = regAddr_e'(pAddr);
    assign wrCtrl = ctrlReg_t'(pWdata);
    assign apbAccess = pSel & pEnable;  // access phase

    // read mux and address decode
    always_comb
    begin
        rdCtrl = '0;
        rdCtrl.laneMask = maskReg;
        rdStatus = '0;
        rdStatus.busy = busy;
        rdStatus.done = done;
        addrHit = 1'b1;
        pRdata = '0;
        case (regSel)
            REG_COLUMN: pRdata = colReg;
            REG_KEY:    pRdata = keyReg;
            REG_CTRL:   pRdata = rdCtrl;
            REG_STATUS: pRdata = rdStatus;
            REG_RESULT: pRdata = resultReg;
            default:    addrHit = 1'b0;  // unmapped offset
        endcase
    end

    assign startReq = apbAccess & pWrite & (regSel == REG_CTRL) & wrCtrl.start;
    assign pReady = ~(startReq & busy);  // only a start during busy waits
    assign pSlvErr = apbAccess & ~addrHit;
    assign wrFire = apbAccess & pWrite & pReady & addrHit;
    assign startFire = startReq & pReady;

    // software registers, STATUS and RESULT ignore writes
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            colReg <= '0;
            keyReg <= '0;
            maskReg <= '0;
        end
        else if (wrFire)
        begin
            case (regSel)
                REG_COLUMN: colReg <= pWdata;
                REG_KEY:    keyReg <= pWdata;
                REG_CTRL:   maskReg <= wrCtrl.laneMask;
                default:    ;
            endcase
        end
    end

    // Busy rises together with the issue pulse and drops after the
    // result is taken, so a single job is outstanding at any time.
    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            issueReg <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            resultReg <= '0;
        end
        else
        begin
            issueReg <= startFire;
            if (startFire)
            begin
                busy <= 1'b1;
                done <= 1'b0;  // cleared by the next start
            end
            else if (resultValid)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (resultValid)
                resultReg <= resultWord;
        end
    end

    assign issueBus.issue = issueReg;
    assign issueBus.colWord = colReg;     // already holds the value of the start write
    assign issueBus.lastMask = maskReg;
    assign issueBus.roundKey = keyReg;

endmodule

`default_nettype wire

// File: aesColumnIfs.sv
`timescale 1ns/1ps
`default_nettype none

// one-cycle issue of a column job from the register block
interface issueIf
    import aesTypesPkg::*;
();
    logic      issue;
    aesWord_t  colWord;
    laneMask_t lastMask;
    aesWord_t  roundKey;

    modport ctrl (output issue, output colWord, output lastMask, output roundKey);
    modport lookup (input issue, input colWord, input lastMask, input roundKey);
    modport xorSide (input issue, input roundKey);  // key side view of the same issue
endinterface

// looked-up lane entries travelling to the XOR cascade
interface laneIf
    import aesTypesPkg::*;
();
    laneWords_t laneWord;
    logic       laneValid;
    aesWord_t   laneKey;    // key of the issue these lanes belong to

    modport src (output laneWord, output laneValid, output laneKey);
    modport dst (input laneWord, input laneValid, input laneKey);
endinterface

`default_nettype wire

// File: aesApbPkg.sv
`default_nettype none

`include "aesColumn_macros.svh"

package aesApbPkg;

    import aesTypesPkg::*;

    typedef enum logic [`APB_ADDR_W-1:0] {
        REG_COLUMN = 'h00,  // state column after ShiftRows
        REG_KEY    = 'h04,  // round-key word
        REG_CTRL   = 'h08,  // lane mask and start
        REG_STATUS = 'h0C,  // busy and done, read only
        REG_RESULT = 'h10   // last captured result, read only
    } regAddr_e;

    typedef struct packed {
        logic [22:0] rsvdHi;
        logic        start;     // write one to launch, reads back zero
        logic [3:0]  rsvdLo;
        laneMask_t   laneMask;
    } ctrlReg_t;

    typedef struct packed {
        logic [29:0] rsvd;
        logic        done;
        logic        busy;
    } statusReg_t;

    // multiply by x modulo the AES polynomial
    function automatic aesByte_t xtime(input aesByte_t a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // shift-and-add GF(2^8) product
    function automatic aesByte_t gfMul(input aesByte_t a, input aesByte_t b);
        aesByte_t acc;
        aesByte_t sh;
        acc = '0;
        sh = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;
            sh = xtime(sh);
        end
        return acc;
    endfunction

    // Inverse as s^254 = s^2 * s^4 * ... * s^128, zero maps to zero,
    // then the affine map written as four left rotations plus 0x63.
    function automatic aesByte_t sbox(input aesByte_t s);
        aesByte_t sq;
        aesByte_t inv;
        sq = s;
        inv = 8'h01;
        for (int i = 1; i < 8; i++)
        begin
            sq = gfMul(sq, sq);
            inv = gfMul(inv, sq);
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                   ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
    endfunction

endpackage

`default_nettype wire

// File: aesTypesPkg.sv
`default_nettype none

`include "aesColumn_macros.svh"

package aesTypesPkg;

    // single state byte, one row of a column
    typedef logic [`AES_BYTE_W-1:0] aesByte_t;

    // state column or round-key word, row 0 in the top byte
    typedef logic [`AES_WORD_W-1:0] aesWord_t;

    // one table entry per lane, index r is lane r
    typedef aesWord_t [`AES_LANES-1:0] laneWords_t;

    // Bit r set means lane r takes the plain S-box byte instead of
    // its T-table entry, as in the final round where MixColumns is skipped.
    typedef logic [`AES_LANES-1:0] laneMask_t;

endpackage

`default_nettype wire

// File: aesColumn_macros.svh
`ifndef AES_COLUMN_MACROS_SVH
`define AES_COLUMN_MACROS_SVH

// datapath geometry
`define AES_WORD_W 32
`define AES_BYTE_W 8
`define AES_LANES 4

// latency of the table read (address register plus output register)
`define LOOKUP_STAGES 2

// one XOR stage per lane, the first one also takes the key
`define XOR_STAGES 4

// covers offsets 0x00 up to 0x1C
`define APB_ADDR_W 5

`endif
